// File: verilog/asa_pkg.sv
// Shared widths, structs and back-pressure thresholds; thresholds assume a 16 deep intake FIFO.
`default_nettype none

package asa_pkg;

	// ----------------------------------------
	// field widths
	// ----------------------------------------
	typedef logic [7:0]  qid_t;
	typedef logic [9:0]  conn_id_t;
	typedef logic [3:0]  port_id_t;
	typedef logic [11:0] buf_ptr_t;
	typedef logic [13:0] pkt_len_t;
	typedef logic [4:0]  read_count_t;

	// ----------------------------------------
	// descriptors
	// ----------------------------------------

	// packet descriptor as it comes from the replicator.
	typedef struct packed {
		port_id_t src_port;
		buf_ptr_t buf_ptr;
		pkt_len_t pkt_len;
	} pkt_desc_t;

	// one replicated copy. The packet id travels beside it.
	typedef struct packed {
		logic      drop;
		logic      ucast;
		logic      last;
		qid_t      qid;
		pkt_desc_t desc;
	} rep_req_t;

	// TM answer to a poll.
	typedef struct packed {
		logic     drop;
		conn_id_t conn_id;
		port_id_t port_id;
	} poll_resp_t;

	// enqueue command to the TM.
	typedef struct packed {
		qid_t      qid;
		conn_id_t  conn_id;
		port_id_t  dst_port;
		pkt_desc_t desc;
	} enq_t;

	// buffer release to the buffer manager.
	typedef struct packed {
		read_count_t read_count;
		port_id_t    port_id;
		buf_ptr_t    buf_ptr;
		pkt_len_t    pkt_len;
	} release_t;

	// ----------------------------------------
	// count table init sequence
	// ----------------------------------------
	typedef enum logic [1:0] {
		init_idle,
		init_sweep,
		init_done
	} init_state_t;

	// intake fill levels for the back-pressure hysteresis.
	localparam int BP_ON = 10;
	localparam int BP_OFF = 6;

endpackage

`default_nettype wire

// File: verilog/sync_fifo.sv
// Register FIFO with show-ahead head; writing when full or reading when empty is not allowed.
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH_LOG2 = 4
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  wr,
	input  wire [WIDTH-1:0]      din,
	input  wire                  rd,
	output logic [WIDTH-1:0]     dout,
	output logic                 empty,
	output logic                 full,
	output logic [DEPTH_LOG2:0]  count
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + DEPTH_LOG2'(wr);
			rd_ptr <= rd_ptr + DEPTH_LOG2'(rd);
			count <= count + (DEPTH_LOG2 + 1)'(wr) - (DEPTH_LOG2 + 1)'(rd);
		end
	end

	// the head is visible in the cycle after its write.
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (DEPTH_LOG2 + 1)'(DEPTH));

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr && full))
		else $error("sync_fifo write while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd && empty))
		else $error("sync_fifo read while empty");

endmodule

`default_nettype wire

// File: verilog/rep_intake.sv
// Intake queue for replicated copies; the sender must stop within 4 cycles of rep_bp.
`timescale 1ns/1ps
`default_nettype none

module rep_intake import asa_pkg::*; #(
	parameter int PKT_ID_W = 6,
	parameter int INTAKE_DEPTH_LOG2 = 4
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 rep_valid,
	input  wire [PKT_ID_W-1:0]  rep_pkt_id,
	input  rep_req_t            rep_req,
	input  wire                 table_ready,
	input  wire                 pend_full,
	output logic                rep_bp,
	output logic                poll_req,
	output qid_t                poll_qid,
	output port_id_t            poll_src_port,
	output logic                pop_valid,
	output logic [PKT_ID_W-1:0] pop_pkt_id,
	output rep_req_t            pop_req
);

	localparam int ENTRY_W = PKT_ID_W + $bits(rep_req_t);

	logic                       fifo_empty;
	logic [ENTRY_W-1:0]         fifo_head;
	logic [INTAKE_DEPTH_LOG2:0] fifo_count;

	sync_fifo #(
		.WIDTH(ENTRY_W),
		.DEPTH_LOG2(INTAKE_DEPTH_LOG2)
	) u_intake_fifo (
		.clk(clk),
		.rst(rst),
		.wr(rep_valid),
		.din({rep_pkt_id, rep_req}),
		.rd(pop_valid),
		.dout(fifo_head),
		.empty(fifo_empty),
		.full(),
		.count(fifo_count)
	);

	// copies leave only after the table sweep and while the tracker has room.
	assign pop_valid = !fifo_empty && table_ready && !pend_full;
	assign {pop_pkt_id, pop_req} = fifo_head;

	always_ff @(posedge clk) begin
		if (rst) begin
			rep_bp <= 1'b0;
			poll_req <= 1'b0;
		end else begin
			poll_req <= pop_valid;
			// the flag holds between the two thresholds.
			if (fifo_count > BP_ON) begin
				rep_bp <= 1'b1;
			end else if (fifo_count < BP_OFF) begin
				rep_bp <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		poll_qid <= pop_req.qid;
		poll_src_port <= pop_req.desc.src_port;
	end

endmodule

`default_nettype wire

// File: verilog/poll_tracker.sv
// Keeps polled copies in poll order; the TM must ack every poll exactly once and in order.
`timescale 1ns/1ps
`default_nettype none

module poll_tracker import asa_pkg::*; #(
	parameter int PKT_ID_W = 6
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 pop_valid,
	input  wire [PKT_ID_W-1:0]  pop_pkt_id,
	input  rep_req_t            pop_req,
	input  wire                 poll_ack,
	input  poll_resp_t          poll_resp,
	output logic                pend_full,
	output logic                enq_valid,
	output enq_t                enq,
	output logic                ack_valid,
	output logic [PKT_ID_W-1:0] ack_pkt_id,
	output logic                ack_final,
	output logic                ack_drop,
	output pkt_desc_t           ack_desc
);

	localparam int PEND_DEPTH_LOG2 = 4;
	localparam int ENTRY_W = PKT_ID_W + $bits(rep_req_t);

	logic               pend_empty;
	logic [ENTRY_W-1:0] pend_head;
	rep_req_t           head_req;

	sync_fifo #(
		.WIDTH(ENTRY_W),
		.DEPTH_LOG2(PEND_DEPTH_LOG2)
	) u_pend_fifo (
		.clk(clk),
		.rst(rst),
		.wr(pop_valid),
		.din({pop_pkt_id, pop_req}),
		.rd(poll_ack),
		.dout(pend_head),
		.empty(pend_empty),
		.full(pend_full),
		.count()
	);

	assign {ack_pkt_id, head_req} = pend_head;

	// the head pairs with the ack that arrives in this cycle.
	assign ack_valid = poll_ack;
	assign ack_final = head_req.ucast || head_req.last;
	assign ack_drop = head_req.drop || poll_resp.drop;
	assign ack_desc = head_req.desc;

	always_ff @(posedge clk) begin
		if (rst) begin
			enq_valid <= 1'b0;
		end else begin
			enq_valid <= poll_ack && !ack_drop;
		end
	end

	always_ff @(posedge clk) begin
		enq.qid <= head_req.qid;
		enq.conn_id <= poll_resp.conn_id;
		enq.dst_port <= poll_resp.port_id;
		enq.desc <= head_req.desc;
	end

	// an ack with no poll outstanding means the TM broke the protocol.
	a_ack_has_poll: assert property (@(posedge clk) disable iff (rst) poll_ack |-> !pend_empty)
		else $error("poll_ack with no outstanding poll");

endmodule

`default_nettype wire

// File: verilog/read_count_table.sv
// Per-packet read counts; acks are accepted only once table_ready is high after the sweep.
`timescale 1ns/1ps
`default_nettype none

module read_count_table import asa_pkg::*; #(
	parameter int PKT_ID_W = 6
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                ack_valid,
	input  wire [PKT_ID_W-1:0] ack_pkt_id,
	input  wire                ack_final,
	input  wire                ack_drop,
	input  pkt_desc_t          ack_desc,
	output logic               table_ready,
	output logic               rc_valid,
	output release_t           rc_rel
);

	localparam int DEPTH = 1 << PKT_ID_W;

	read_count_t mem [DEPTH];

	init_state_t         init_state;
	logic [PKT_ID_W-1:0] init_addr;

	// stage 1 holds the RAM data of the ack from the previous cycle.
	logic                s1_valid;
	logic [PKT_ID_W-1:0] s1_pkt_id;
	logic                s1_final;
	logic                s1_drop;
	pkt_desc_t           s1_desc;
	read_count_t         s1_rdata;

	// stage 2 holds the write of the current cycle.
	logic                s2_valid;
	logic [PKT_ID_W-1:0] s2_pkt_id;
	logic                s2_final;
	pkt_desc_t           s2_desc;
	read_count_t         s2_sum;
	read_count_t         s2_wdata;

	// the write of the cycle before, which the RAM read may have missed.
	logic                wd1_valid;
	logic [PKT_ID_W-1:0] wd1_pkt_id;
	read_count_t         wd1_data;

	read_count_t base;
	read_count_t sum;

	// ----------------------------------------
	// init sweep
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			init_state <= init_idle;
			init_addr <= '0;
			table_ready <= 1'b0;
		end else begin
			table_ready <= (init_state == init_done);
			case (init_state)
				init_idle: init_state <= init_sweep;
				init_sweep: begin
					init_addr <= init_addr + 1'b1;
					if (&init_addr) begin
						init_state <= init_done;
					end
				end
				default: init_state <= init_done;
			endcase
		end
	end

	// ----------------------------------------
	// count RAM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (init_state == init_sweep) begin
			mem[init_addr] <= '0;
		end else if (s2_valid) begin
			mem[s2_pkt_id] <= s2_wdata;
		end
		s1_rdata <= mem[ack_pkt_id];
	end

	// ----------------------------------------
	// read-modify-write pipeline
	// ----------------------------------------

	// the newest write to the same entry wins.
	always_comb begin
		if (s2_valid && (s2_pkt_id == s1_pkt_id)) begin
			base = s2_wdata;
		end else if (wd1_valid && (wd1_pkt_id == s1_pkt_id)) begin
			base = wd1_data;
		end else begin
			base = s1_rdata;
		end
		sum = base + read_count_t'(!s1_drop);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			wd1_valid <= 1'b0;
		end else begin
			s1_valid <= ack_valid;
			s2_valid <= s1_valid;
			wd1_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_pkt_id <= ack_pkt_id;
		s1_final <= ack_final;
		s1_drop <= ack_drop;
		s1_desc <= ack_desc;
		s2_pkt_id <= s1_pkt_id;
		s2_final <= s1_final;
		s2_desc <= s1_desc;
		s2_sum <= sum;
		// a final copy leaves the entry cleared for the next packet.
		s2_wdata <= s1_final ? '0 : sum;
		wd1_pkt_id <= s2_pkt_id;
		wd1_data <= s2_wdata;
	end

	assign rc_valid = s2_valid && s2_final;
	assign rc_rel.read_count = s2_sum;
	assign rc_rel.port_id = s2_desc.src_port;
	assign rc_rel.buf_ptr = s2_desc.buf_ptr;
	assign rc_rel.pkt_len = s2_desc.pkt_len;

	// an ack during the sweep would be lost under the zero writes.
	a_ack_after_sweep: assert property (@(posedge clk) disable iff (rst) ack_valid |-> table_ready)
		else $error("ack before the count table is ready");

endmodule

`default_nettype wire

// File: verilog/release_merge.sv
// Release port merge; a discard always wins and table releases wait, up to 32 of them.
`timescale 1ns/1ps
`default_nettype none

module release_merge import asa_pkg::*; (
	input  wire      clk,
	input  wire      rst,
	input  wire      rc_valid,
	input  release_t rc_rel,
	input  wire      discard_req,
	input  release_t discard,
	output logic     rel_valid,
	output release_t rel
);

	localparam int REL_DEPTH_LOG2 = 5;

	logic     rel_empty;
	logic     rel_rd;
	release_t rel_head;
	release_t discard_rel;

	sync_fifo #(
		.WIDTH($bits(release_t)),
		.DEPTH_LOG2(REL_DEPTH_LOG2)
	) u_rel_fifo (
		.clk(clk),
		.rst(rst),
		.wr(rc_valid),
		.din(rc_rel),
		.rd(rel_rd),
		.dout(rel_head),
		.empty(rel_empty),
		.full(),
		.count()
	);

	// discarded buffers have no readers.
	always_comb begin
		discard_rel = discard;
		discard_rel.read_count = '0;
	end

	assign rel_rd = !discard_req && !rel_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			rel_valid <= 1'b0;
		end else begin
			rel_valid <= discard_req || !rel_empty;
		end
	end

	always_ff @(posedge clk) begin
		rel <= discard_req ? discard_rel : rel_head;
	end

endmodule

`default_nettype wire

// File: verilog/asa_tm_top.sv
// Attach stage between replicator and TM; TM and buffer manager must accept every cycle.
`timescale 1ns/1ps
`default_nettype none

module asa_tm_top import asa_pkg::*; #(
	parameter int PKT_ID_W = 6,
	parameter int INTAKE_DEPTH_LOG2 = 4
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                rep_valid,
	input  wire [PKT_ID_W-1:0] rep_pkt_id,
	input  rep_req_t           rep_req,
	output logic               rep_bp,
	output logic               poll_req,
	output qid_t               poll_qid,
	output port_id_t           poll_src_port,
	input  wire                poll_ack,
	input  poll_resp_t         poll_resp,
	output logic               enq_valid,
	output enq_t               enq,
	input  wire                discard_req,
	input  release_t           discard,
	output logic               rel_valid,
	output release_t           rel
);

	logic                pop_valid;
	logic [PKT_ID_W-1:0] pop_pkt_id;
	rep_req_t            pop_req;
	logic                pend_full;
	logic                table_ready;

	logic                ack_valid;
	logic [PKT_ID_W-1:0] ack_pkt_id;
	logic                ack_final;
	logic                ack_drop;
	pkt_desc_t           ack_desc;

	logic                rc_valid;
	release_t            rc_rel;

	rep_intake #(
		.PKT_ID_W(PKT_ID_W),
		.INTAKE_DEPTH_LOG2(INTAKE_DEPTH_LOG2)
	) u_rep_intake (
		.clk(clk),
		.rst(rst),
		.rep_valid(rep_valid),
		.rep_pkt_id(rep_pkt_id),
		.rep_req(rep_req),
		.table_ready(table_ready),
		.pend_full(pend_full),
		.rep_bp(rep_bp),
		.poll_req(poll_req),
		.poll_qid(poll_qid),
		.poll_src_port(poll_src_port),
		.pop_valid(pop_valid),
		.pop_pkt_id(pop_pkt_id),
		.pop_req(pop_req)
	);

	poll_tracker #(
		.PKT_ID_W(PKT_ID_W)
	) u_poll_tracker (
		.clk(clk),
		.rst(rst),
		.pop_valid(pop_valid),
		.pop_pkt_id(pop_pkt_id),
		.pop_req(pop_req),
		.poll_ack(poll_ack),
		.poll_resp(poll_resp),
		.pend_full(pend_full),
		.enq_valid(enq_valid),
		.enq(enq),
		.ack_valid(ack_valid),
		.ack_pkt_id(ack_pkt_id),
		.ack_final(ack_final),
		.ack_drop(ack_drop),
		.ack_desc(ack_desc)
	);

	read_count_table #(
		.PKT_ID_W(PKT_ID_W)
	) u_read_count_table (
		.clk(clk),
		.rst(rst),
		.ack_valid(ack_valid),
		.ack_pkt_id(ack_pkt_id),
		.ack_final(ack_final),
		.ack_drop(ack_drop),
		.ack_desc(ack_desc),
		.table_ready(table_ready),
		.rc_valid(rc_valid),
		.rc_rel(rc_rel)
	);

	release_merge u_release_merge (
		.clk(clk),
		.rst(rst),
		.rc_valid(rc_valid),
		.rc_rel(rc_rel),
		.discard_req(discard_req),
		.discard(discard),
		.rel_valid(rel_valid),
		.rel(rel)
	);

endmodule

`default_nettype wire

// File: tb/asa_tm_checks.sv
// Reference model and checkers for the attach stage; assumes in-order acks and no sender overrun.
`timescale 1ns/1ps
`default_nettype none

module asa_tm_checks import asa_pkg::*; #(
	parameter int PKT_ID_W = 6
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                rep_valid,
	input  wire [PKT_ID_W-1:0] rep_pkt_id,
	input  rep_req_t           rep_req,
	input  wire                rep_bp,
	input  wire                poll_req,
	input  qid_t               poll_qid,
	input  port_id_t           poll_src_port,
	input  wire                poll_ack,
	input  poll_resp_t         poll_resp,
	input  wire                enq_valid,
	input  enq_t               enq,
	input  wire                discard_req,
	input  release_t           discard,
	input  wire                rel_valid,
	input  release_t           rel,
	output int                 value_errors,
	output int                 assert_errors,
	output logic               idle
);

	localparam int DEPTH = 1 << PKT_ID_W;

	typedef struct packed {
		logic [PKT_ID_W-1:0] id;
		rep_req_t            req;
	} copy_t;

	copy_t       rep_q[$];
	copy_t       pend_q[$];
	release_t    rel_q[$];
	read_count_t cnt [DEPTH];

	logic        want_enq;
	enq_t        exp_enq;
	logic        disc_seen;
	release_t    exp_disc;
	logic        exp_bp;
	int unsigned since_rst;

	// ----------------------------------------
	// model and data checks
	// ----------------------------------------
	always @(posedge clk) begin
		copy_t    c;
		logic     drop;
		release_t r;
		int       fill;
		if (rst) begin
			rep_q.delete();
			pend_q.delete();
			rel_q.delete();
			for (int i = 0; i < DEPTH; i++) begin
				cnt[i] = '0;
			end
			want_enq = 1'b0;
			disc_seen = 1'b0;
			exp_bp = 1'b0;
			since_rst = 0;
			value_errors = 0;
			idle = 1'b1;
		end else begin
			since_rst++;

			// a poll in the cycle just ended means its copy had already left the intake.
			fill = rep_q.size() - int'(poll_req);
			assert (rep_bp == exp_bp) else begin
				$display("ERROR rep_bp: got %h expected %h", rep_bp, exp_bp);
				value_errors++;
			end
			if (fill > BP_ON) begin
				exp_bp = 1'b1;
			end else if (fill < BP_OFF) begin
				exp_bp = 1'b0;
			end

			assert (enq_valid == want_enq) else begin
				$display("ERROR enq_valid: got %h expected %h", enq_valid, want_enq);
				value_errors++;
			end
			if (enq_valid && want_enq) begin
				assert (enq == exp_enq) else begin
					$display("ERROR enq: got %h expected %h", enq, exp_enq);
					value_errors++;
				end
			end

			if (disc_seen) begin
				assert (!rel_valid || rel == exp_disc) else begin
					$display("ERROR rel: got %h expected %h", rel, exp_disc);
					value_errors++;
				end
			end else if (rel_valid) begin
				if (rel_q.size() == 0) begin
					$display("release seen with no packet release outstanding");
					value_errors++;
				end else begin
					r = rel_q.pop_front();
					assert (rel == r) else begin
						$display("ERROR rel: got %h expected %h", rel, r);
						value_errors++;
					end
				end
			end

			if (poll_req) begin
				if (rep_q.size() == 0) begin
					$display("poll issued with no copy in the intake");
					value_errors++;
				end else begin
					c = rep_q.pop_front();
					assert (poll_qid == c.req.qid) else begin
						$display("ERROR poll_qid: got %h expected %h", poll_qid, c.req.qid);
						value_errors++;
					end
					assert (poll_src_port == c.req.desc.src_port) else begin
						$display("ERROR poll_src_port: got %h expected %h",
							poll_src_port, c.req.desc.src_port);
						value_errors++;
					end
					pend_q.push_back(c);
				end
			end

			want_enq = 1'b0;
			if (poll_ack) begin
				if (pend_q.size() == 0) begin
					$display("ack arrived with no poll outstanding");
					value_errors++;
				end else begin
					c = pend_q.pop_front();
					drop = c.req.drop || poll_resp.drop;
					if (!drop) begin
						want_enq = 1'b1;
						exp_enq.qid = c.req.qid;
						exp_enq.conn_id = poll_resp.conn_id;
						exp_enq.dst_port = poll_resp.port_id;
						exp_enq.desc = c.req.desc;
						cnt[c.id] = cnt[c.id] + 5'd1;
					end
					if (c.req.ucast || c.req.last) begin
						r.read_count = cnt[c.id];
						r.port_id = c.req.desc.src_port;
						r.buf_ptr = c.req.desc.buf_ptr;
						r.pkt_len = c.req.desc.pkt_len;
						rel_q.push_back(r);
						cnt[c.id] = '0;
					end
				end
			end

			disc_seen = discard_req;
			exp_disc = discard;
			exp_disc.read_count = '0;

			if (rep_valid) begin
				c.id = rep_pkt_id;
				c.req = rep_req;
				rep_q.push_back(c);
			end

			idle = (rep_q.size() == 0) && (pend_q.size() == 0) && (rel_q.size() == 0)
				&& !want_enq;
		end
	end

	// ----------------------------------------
	// timing checks
	// ----------------------------------------
	initial assert_errors = 0;

	a_reset_quiet: assert property (@(posedge clk)
		$past(rst) |-> !rep_bp && !poll_req && !enq_valid && !rel_valid)
		else begin
			$display("outputs not quiet right after reset");
			assert_errors++;
		end

	a_poll_after_sweep: assert property (@(posedge clk) disable iff (rst)
		poll_req |-> since_rst >= DEPTH)
		else begin
			$display("poll issued before the count table sweep could finish");
			assert_errors++;
		end

	a_discard_next: assert property (@(posedge clk) disable iff (rst)
		discard_req |=> rel_valid)
		else begin
			$display("discard did not reach the release port one cycle later");
			assert_errors++;
		end

	a_enq_after_ack: assert property (@(posedge clk) disable iff (rst)
		enq_valid |-> $past(poll_ack))
		else begin
			$display("enqueue issued without an ack in the cycle before");
			assert_errors++;
		end

endmodule

`default_nettype wire

// File: tb/asa_tm_tb.sv
// Testbench for the attach stage; TM model acks in order, stimulus is seeded and repeatable.
`timescale 1ns/1ps
`default_nettype none

module asa_tm_tb import asa_pkg::*; ();

	localparam int PKT_ID_W = 6;
	localparam int NUM_COPIES = 300;
	localparam int HOLD_AFTER = 120;
	// 300 copies at up to 8 cycles, the init sweep, and margin for the hold and bursts.
	localparam int TIMEOUT_CYCLES = 4000;

	logic                clk;
	logic                rst;
	logic                rep_valid;
	logic [PKT_ID_W-1:0] rep_pkt_id;
	rep_req_t            rep_req;
	logic                rep_bp;
	logic                poll_req;
	qid_t                poll_qid;
	port_id_t            poll_src_port;
	logic                poll_ack;
	poll_resp_t          poll_resp;
	logic                enq_valid;
	enq_t                enq;
	logic                discard_req;
	release_t            discard;
	logic                rel_valid;
	release_t            rel;

	int          value_errors;
	int          assert_errors;
	int          other_errors;
	logic        idle;
	int unsigned cycle;
	int          copies_sent;
	logic        traffic_on;
	logic        hold;
	logic        bp_seen;

	logic [31:0] stim_seed;
	logic [31:0] tm_seed;
	logic [31:0] disc_seed;
	int unsigned ack_due[$];
	int unsigned last_due;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	asa_tm_top #(
		.PKT_ID_W(PKT_ID_W),
		.INTAKE_DEPTH_LOG2(4)
	) UUT (
		.clk(clk),
		.rst(rst),
		.rep_valid(rep_valid),
		.rep_pkt_id(rep_pkt_id),
		.rep_req(rep_req),
		.rep_bp(rep_bp),
		.poll_req(poll_req),
		.poll_qid(poll_qid),
		.poll_src_port(poll_src_port),
		.poll_ack(poll_ack),
		.poll_resp(poll_resp),
		.enq_valid(enq_valid),
		.enq(enq),
		.discard_req(discard_req),
		.discard(discard),
		.rel_valid(rel_valid),
		.rel(rel)
	);

	asa_tm_checks #(
		.PKT_ID_W(PKT_ID_W)
	) u_checks (
		.clk(clk),
		.rst(rst),
		.rep_valid(rep_valid),
		.rep_pkt_id(rep_pkt_id),
		.rep_req(rep_req),
		.rep_bp(rep_bp),
		.poll_req(poll_req),
		.poll_qid(poll_qid),
		.poll_src_port(poll_src_port),
		.poll_ack(poll_ack),
		.poll_resp(poll_resp),
		.enq_valid(enq_valid),
		.enq(enq),
		.discard_req(discard_req),
		.discard(discard),
		.rel_valid(rel_valid),
		.rel(rel),
		.value_errors(value_errors),
		.assert_errors(assert_errors),
		.idle(idle)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not drain", cycle);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// TM model
	// ----------------------------------------

	// each poll gets a due cycle 1 to 6 cycles out, never before the previous one.
	always @(posedge clk) begin
		int unsigned due;
		if (poll_req) begin
			tm_seed = lcg_next(tm_seed);
			due = cycle + 1 + (tm_seed[31:16] % 6);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			ack_due.push_back(due);
			last_due = due;
		end
	end

	always @(negedge clk) begin
		poll_ack = 1'b0;
		if (!hold && ack_due.size() > 0 && ack_due[0] <= cycle) begin
			void'(ack_due.pop_front());
			tm_seed = lcg_next(tm_seed);
			poll_ack = 1'b1;
			poll_resp.drop = (tm_seed[31:16] % 6) == 0;
			poll_resp.conn_id = tm_seed[25:16];
			poll_resp.port_id = tm_seed[29:26];
		end
	end

	// background discards, with a solid burst to starve the table releases.
	always @(negedge clk) begin
		logic burst;
		burst = (cycle >= 320) && (cycle < 350);
		disc_seed = lcg_next(disc_seed);
		if (traffic_on && (burst || (disc_seed[31:16] % 10) == 0)) begin
			discard_req = 1'b1;
			discard.read_count = disc_seed[20:16];
			discard.port_id = disc_seed[24:21];
			discard.buf_ptr = disc_seed[31:20];
			discard.pkt_len = disc_seed[29:16];
		end else begin
			discard_req = 1'b0;
		end
	end

	// acks are withheld until the intake pushes back, then released.
	initial begin
		hold = 1'b0;
		bp_seen = 1'b0;
		wait (copies_sent >= HOLD_AFTER);
		@(negedge clk);
		hold = 1'b1;
		wait (rep_bp);
		bp_seen = 1'b1;
		repeat (30) @(negedge clk);
		hold = 1'b0;
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic send_packet(input logic [PKT_ID_W-1:0] id);
		int        n;
		pkt_desc_t desc;
		stim_seed = lcg_next(stim_seed);
		n = 1 + int'(stim_seed[17:16]);
		desc.src_port = stim_seed[21:18];
		desc.buf_ptr = stim_seed[31:20];
		stim_seed = lcg_next(stim_seed);
		desc.pkt_len = stim_seed[29:16];
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			stim_seed = lcg_next(stim_seed);
			if (stim_seed[17:16] == 2'd0) begin
				rep_valid = 1'b0;
				@(negedge clk);
			end
			while (rep_bp) begin
				rep_valid = 1'b0;
				@(negedge clk);
			end
			rep_valid = 1'b1;
			rep_pkt_id = id;
			rep_req.drop = (stim_seed[31:16] % 5) == 0;
			rep_req.ucast = (n == 1);
			rep_req.last = (i == n - 1);
			rep_req.qid = stim_seed[27:20];
			rep_req.desc = desc;
			copies_sent++;
		end
	endtask

	initial begin
		logic [PKT_ID_W-1:0] pkt_id;
		stim_seed = 32'd32658;
		tm_seed = 32'd32658;
		disc_seed = 32'd32658;
		cycle = 0;
		last_due = 0;
		copies_sent = 0;
		other_errors = 0;
		traffic_on = 1'b0;
		rst = 1'b1;
		rep_valid = 1'b0;
		rep_pkt_id = '0;
		rep_req = '0;
		poll_ack = 1'b0;
		poll_resp = '0;
		discard_req = 1'b0;
		discard = '0;
		pkt_id = '0;

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		traffic_on = 1'b1;

		while (copies_sent < NUM_COPIES) begin
			send_packet(pkt_id);
			pkt_id = pkt_id + 1'b1;
		end
		@(negedge clk);
		rep_valid = 1'b0;

		// drain every copy through the TM and the release port.
		wait (ack_due.size() == 0 && !hold);
		repeat (20) @(negedge clk);
		traffic_on = 1'b0;
		wait (idle);
		repeat (40) @(negedge clk);

		if (!bp_seen) begin
			$display("rep_bp never rose while acks were withheld");
			other_errors++;
		end
		if (rep_bp) begin
			$display("rep_bp still high after the intake drained");
			other_errors++;
		end
		if (!idle) begin
			$display("model still expects copies or releases at the end");
			other_errors++;
		end

		$display("errors: value %0d, assertion %0d, other %0d",
			value_errors, assert_errors, other_errors);
		if (value_errors + assert_errors + other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
verilog/asa_pkg.sv
verilog/sync_fifo.sv
verilog/rep_intake.sv
verilog/poll_tracker.sv
verilog/read_count_table.sv
verilog/release_merge.sv
verilog/asa_tm_top.sv
tb/asa_tm_checks.sv
tb/asa_tm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the attach stage testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module asa_tm_tb -o asa_tm_sim; then
	echo "verilator compile failed"
	exit 1
fi

out="$(./obj_dir/asa_tm_sim 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1
